/* design/synth_pkg.sv */
`default_nettype none

package synth_pkg;

	localparam int FIFO_DEPTH   = 4;  // queued note events, also starting credits
	localparam int FRAME_CYCLES = 64; // clk50mhz cycles per frame tick
	localparam int LEN_TICKS    = 2;  // frame ticks per length unit
	localparam int STEP_SCALE   = 2;  // step divisor = STEP_SCALE * (64 - pitch)

	localparam int NOTE_W     = 6;
	localparam int LEN_W      = 3;
	localparam int NOTE_RANGE = 1 << NOTE_W; // 64 pitch codes

	// derived widths
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int CREDIT_W   = $clog2(FIFO_DEPTH + 1);
	localparam int FRAME_W    = $clog2(FRAME_CYCLES);
	localparam int TICKS_W    = $clog2((1 << LEN_W) * LEN_TICKS + 1);
	localparam int DIV_W      = $clog2(STEP_SCALE * NOTE_RANGE + 1);

	typedef enum logic [1:0] {
		fx_none     = 2'd0,
		fx_porta    = 2'd1,
		fx_vibrato  = 2'd2,
		fx_reserved = 2'd3 // plays the note as written
	} fx_sel_e;

	// option bits, read one way for portamento and another for vibrato
	typedef union packed {
		struct packed {
			logic [1:0] rsvd;  // unused by portamento
			logic [1:0] speed; // ticks per code step, minus one
		} porta;
		struct packed {
			logic [1:0] depth; // excursion above target, minus one
			logic [1:0] speed; // ticks per toggle, minus one
		} vib;
	} fx_opt_u;

	// 15 bit note event
	typedef struct packed {
		logic [NOTE_W-1:0] code;
		logic [LEN_W-1:0]  length;
		fx_sel_e           fx_sel;
		fx_opt_u           fx_opt;
	} note_event_t;

endpackage

`default_nettype wire

/* design/note_if.sv */
`timescale 1ns/1ps
`default_nettype none

// note events from sequencer into fifo, head event out to the channel
interface note_if import synth_pkg::*; ();

	logic        send_valid;    // one event per cycle, only with a credit held
	note_event_t send_event;
	logic        pop;           // channel takes the head event
	note_event_t pop_event;     // fifo head
	logic        not_empty;
	logic        credit_return; // one pulse per pop

	modport sender (
		output send_valid,
		output send_event,
		input  credit_return
	);

	modport buffer (
		input  send_valid,
		input  send_event,
		input  pop,
		output pop_event,
		output not_empty,
		output credit_return
	);

	modport receiver (
		output pop,
		input  pop_event,
		input  not_empty
	);

endinterface

`default_nettype wire

/* design/note_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module note_sequencer import synth_pkg::*; (
	input  wire logic              clk50mhz,
	input  wire logic              reset,
	input  wire logic              note_valid,
	input  wire logic [NOTE_W-1:0] note_code,
	input  wire logic [LEN_W-1:0]  note_length,
	input  wire fx_sel_e           fx_sel,
	input  wire fx_opt_u           fx_opt,
	output logic                   host_ready,
	note_if.sender                 link
);

	logic [CREDIT_W-1:0] credits; // free fifo slots as seen from here
	logic                accept;
	note_event_t         host_event;

	assign host_ready = (credits != '0);
	assign accept     = note_valid && host_ready; // writes without a credit are dropped

	// pack the host fields
	always_comb
	begin
		host_event.code   = note_code;
		host_event.length = note_length;
		host_event.fx_sel = fx_sel;
		host_event.fx_opt = fx_opt;
	end

	// one cycle register stage onto the link
	always_ff @(posedge clk50mhz)
	begin
		if (reset)
		begin
			link.send_valid <= 1'b0;
		end
		else
		begin
			link.send_valid <= accept;
		end
		if (accept)
			link.send_event <= host_event; // payload, held between sends
	end

	// credit taken when the write is accepted, so the stage in flight is covered
	always_ff @(posedge clk50mhz)
	begin
		if (reset)
		begin
			credits <= CREDIT_W'(FIFO_DEPTH);
		end
		else
		begin
			case ({accept, link.credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits; // none, or both cancel
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/note_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module note_fifo import synth_pkg::*; (
	input  wire logic clk50mhz,
	input  wire logic reset,
	note_if.buffer    link
);

	note_event_t           mem [FIFO_DEPTH]; // event storage
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [CREDIT_W-1:0]   count;            // occupancy 0..FIFO_DEPTH
	logic                  do_pop;

	assign link.not_empty     = (count != '0);
	assign link.pop_event     = mem[rd_ptr];               // head shown directly
	assign do_pop             = link.pop && link.not_empty;
	assign link.credit_return = do_pop;                    // same cycle as pop

	// no full check, the credit scheme keeps writes within depth
	always_ff @(posedge clk50mhz)
	begin
		if (link.send_valid)
			mem[wr_ptr] <= link.send_event;
	end

	always_ff @(posedge clk50mhz)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (link.send_valid)
			begin
				// wrap at depth
				if (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				if (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			case ({link.send_valid, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/fx_pitch.sv */
`timescale 1ns/1ps
`default_nettype none

module fx_pitch import synth_pkg::*; (
	input  wire logic              clk50mhz,
	input  wire logic              reset,
	input  wire logic              frame_tick,
	input  wire logic              load,
	input  wire logic [NOTE_W-1:0] target,
	input  wire fx_sel_e           fx_sel,
	input  wire fx_opt_u           fx_opt,
	output logic [NOTE_W-1:0]      pitch_code
);

	logic [NOTE_W-1:0] tgt;      // latched target note
	fx_sel_e           sel_q;
	fx_opt_u           opt_q;
	logic [1:0]        rate_cnt; // frame ticks since last effect step
	logic [1:0]        speed;
	logic              vib_hi;   // vibrato currently at upper pitch
	logic [NOTE_W:0]   vib_sum;  // one extra bit for overflow
	logic [NOTE_W-1:0] vib_top;

	// speed shares bits 1:0 in both views
	assign speed   = opt_q.porta.speed;
	assign vib_sum = {1'b0, tgt} + (NOTE_W+1)'(opt_q.vib.depth) + (NOTE_W+1)'(1);
	assign vib_top = vib_sum[NOTE_W] ? {NOTE_W{1'b1}} : vib_sum[NOTE_W-1:0]; // clamp at 63

	always_ff @(posedge clk50mhz)
	begin
		if (reset)
		begin
			tgt        <= '0;
			sel_q      <= fx_none;
			opt_q      <= '0;
			rate_cnt   <= '0;
			vib_hi     <= 1'b0;
			pitch_code <= '0;
		end
		else if (load)
		begin
			tgt      <= target;
			sel_q    <= fx_sel;
			opt_q    <= fx_opt;
			rate_cnt <= '0;
			vib_hi   <= 1'b0;
			if (fx_sel != fx_porta)
				pitch_code <= target; // porta keeps old pitch and glides
		end
		else if (frame_tick)
		begin
			if (rate_cnt == speed)
			begin
				rate_cnt <= '0;
				case (sel_q)
					fx_porta:
					begin
						if (pitch_code < tgt)
							pitch_code <= pitch_code + 1'b1;
						else if (pitch_code > tgt)
							pitch_code <= pitch_code - 1'b1;
					end
					fx_vibrato:
					begin
						vib_hi     <= ~vib_hi;
						pitch_code <= vib_hi ? tgt : vib_top;
					end
					default: pitch_code <= tgt; // none and reserved hold target
				endcase
			end
			else
			begin
				rate_cnt <= rate_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/tri_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module tri_channel import synth_pkg::*; (
	input  wire logic         clk50mhz,
	input  wire logic         reset,
	note_if.receiver          link,
	output logic [3:0]        wave_out,
	output logic              voice_active,
	output logic [NOTE_W-1:0] pitch_code
);

	logic [FRAME_W-1:0] frame_cnt;  // free running
	logic               frame_tick; // one cycle per frame
	logic [TICKS_W-1:0] ticks_left; // frame ticks until silence
	logic [DIV_W-1:0]   div_cnt;    // cycles until next phase step
	logic [4:0]         phase;      // 0..31, folded to the triangle
	logic               active;

	// cycles per phase step for a pitch code
	function automatic logic [DIV_W-1:0] step_cycles(input logic [NOTE_W-1:0] code);
		step_cycles = DIV_W'(STEP_SCALE) * (DIV_W'(NOTE_RANGE) - DIV_W'(code));
	endfunction

	assign link.pop     = !active && link.not_empty; // take a note whenever idle
	assign frame_tick   = (frame_cnt == FRAME_W'(FRAME_CYCLES - 1));
	assign voice_active = active;
	// upper half runs 15 down to 0, silent when idle
	assign wave_out     = active ? (phase[4] ? ~phase[3:0] : phase[3:0]) : 4'd0;

	always_ff @(posedge clk50mhz)
	begin
		if (reset)
			frame_cnt <= '0;
		else
			frame_cnt <= frame_cnt + 1'b1; // wraps at FRAME_CYCLES
	end

	// load on pop, then count length down in frame ticks
	always_ff @(posedge clk50mhz)
	begin
		if (reset)
		begin
			active     <= 1'b0;
			ticks_left <= '0;
		end
		else if (!active)
		begin
			if (link.pop)
			begin
				active     <= 1'b1;
				ticks_left <= TICKS_W'((link.pop_event.length + 1) * LEN_TICKS);
			end
		end
		else if (frame_tick)
		begin
			if (ticks_left == TICKS_W'(1))
				active <= 1'b0; // length used up
			ticks_left <= ticks_left - 1'b1;
		end
	end

	// step divider and phase counter
	always_ff @(posedge clk50mhz)
	begin
		if (reset)
		begin
			phase   <= '0;
			div_cnt <= '0;
		end
		else if (!active)
		begin
			if (link.pop)
			begin
				phase   <= '0;
				div_cnt <= step_cycles(link.pop_event.code) - 1'b1;
			end
		end
		else if (div_cnt == '0)
		begin
			phase   <= phase + 1'b1;                 // 31 wraps to 0
			div_cnt <= step_cycles(pitch_code) - 1'b1; // follows effect pitch
		end
		else
		begin
			div_cnt <= div_cnt - 1'b1;
		end
	end

	fx_pitch u_fx_pitch (
		.clk50mhz   (clk50mhz),
		.reset      (reset),
		.frame_tick (frame_tick),
		.load       (link.pop),
		.target     (link.pop_event.code),
		.fx_sel     (link.pop_event.fx_sel),
		.fx_opt     (link.pop_event.fx_opt),
		.pitch_code (pitch_code)
	);

endmodule

`default_nettype wire

/* design/tri_synth_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tri_synth_top import synth_pkg::*; (
	input  wire logic              clk50mhz,
	input  wire logic              reset,
	input  wire logic              note_valid,
	input  wire logic [NOTE_W-1:0] note_code,
	input  wire logic [LEN_W-1:0]  note_length,
	input  wire fx_sel_e           fx_sel,
	input  wire fx_opt_u           fx_opt,
	output logic                   host_ready,
	output logic [3:0]             wave_out,
	output logic                   voice_active,
	output logic [NOTE_W-1:0]      pitch_code
);

	note_if link (); // sequencer -> fifo -> channel

	note_sequencer u_sequencer (
		.clk50mhz    (clk50mhz),
		.reset       (reset),
		.note_valid  (note_valid),
		.note_code   (note_code),
		.note_length (note_length),
		.fx_sel      (fx_sel),
		.fx_opt      (fx_opt),
		.host_ready  (host_ready),
		.link        (link.sender)
	);

	note_fifo u_fifo (
		.clk50mhz (clk50mhz),
		.reset    (reset),
		.link     (link.buffer)
	);

	tri_channel u_channel (
		.clk50mhz     (clk50mhz),
		.reset        (reset),
		.link         (link.receiver),
		.wave_out     (wave_out),
		.voice_active (voice_active),
		.pitch_code   (pitch_code)
	);

endmodule

`default_nettype wire

/* tests/tb_tri_synth.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tri_synth import synth_pkg::*;;

	localparam int UNIT_CYCLES  = LEN_TICKS * FRAME_CYCLES; // cycles per length unit
	localparam int NOTE_UNITS   = 8 + 36 + 24 + 9 + 8;       // worst-case length units over all tests
	localparam int NOTE_COUNT   = 19;                        // notes played over the run
	localparam int WATCH_CYCLES = (NOTE_UNITS * UNIT_CYCLES + NOTE_COUNT * 16 + 200) * 12 / 10;
	localparam int START_LIMIT  = 16;                        // pop latency is a few cycles
	localparam int IDLE_LIMIT   = 8 * UNIT_CYCLES + FRAME_CYCLES;

	logic              clk50mhz = 1'b0;
	logic              reset;
	logic              note_valid;
	logic [NOTE_W-1:0] note_code;
	logic [LEN_W-1:0]  note_length;
	fx_sel_e           fx_sel;
	fx_opt_u           fx_opt;
	logic              host_ready;
	logic [3:0]        wave_out;
	logic              voice_active;
	logic [NOTE_W-1:0] pitch_code;
	int                errors = 0;

	always #10 clk50mhz = ~clk50mhz; // 50 MHz

	tri_synth_top u_dut (
		.clk50mhz     (clk50mhz),
		.reset        (reset),
		.note_valid   (note_valid),
		.note_code    (note_code),
		.note_length  (note_length),
		.fx_sel       (fx_sel),
		.fx_opt       (fx_opt),
		.host_ready   (host_ready),
		.wave_out     (wave_out),
		.voice_active (voice_active),
		.pitch_code   (pitch_code)
	);

	// drive and sample just after the edge
	task automatic next_cycle();
		@(posedge clk50mhz);
		#2;
	endtask

	task automatic check_pitch(input logic [NOTE_W-1:0] exp, input logic [NOTE_W-1:0] act);
		if (act !== exp)
		begin
			errors++;
			$display("[FAIL] pitch_code: expected %h, got %h at %0t", exp, act, $time);
		end
	endtask

	task automatic check_wave(input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp)
		begin
			errors++;
			$display("[FAIL] wave_out: expected %h, got %h at %0t", exp, act, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			errors++;
			$display("[FAIL] %s: expected %h, got %h at %0t", name, exp, act, $time);
		end
	endtask

	// one-cycle host write that ignores host_ready
	task automatic write_note(input logic [NOTE_W-1:0] code, input logic [LEN_W-1:0] len,
			input fx_sel_e sel, input fx_opt_u opt);
		note_valid  = 1'b1;
		note_code   = code;
		note_length = len;
		fx_sel      = sel;
		fx_opt      = opt;
		next_cycle();
		note_valid  = 1'b0;
	endtask

	task automatic wait_active();
		int n;
		n = 0;
		while (!voice_active && n < START_LIMIT)
		begin
			next_cycle();
			n++;
		end
		if (!voice_active)
		begin
			errors++;
			$display("voice never became active, at %0t", $time);
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (voice_active && n < IDLE_LIMIT)
		begin
			next_cycle();
			n++;
		end
		if (voice_active)
		begin
			errors++;
			$display("voice never went silent, at %0t", $time);
		end
	endtask

	task automatic reset_values();
		check_flag("host_ready", 1'b1, host_ready);
		check_flag("voice_active", 1'b0, voice_active);
		check_wave(4'd0, wave_out);
		check_pitch('0, pitch_code);
	endtask

	// triangle model shows k on step k below 16 and 31-k above
	task automatic plain_note();
		logic [NOTE_W-1:0] code;
		logic [LEN_W-1:0]  len;
		logic [3:0]        exp_wave;
		int                step_len;
		int                c;
		int                ph;
		code     = NOTE_W'($urandom_range(52, 63)); // short steps so a full period fits
		len      = LEN_W'($urandom_range(6, 7));
		step_len = STEP_SCALE * (NOTE_RANGE - int'(code));
		write_note(code, len, fx_none, '0);
		wait_active();
		c = 0;
		while (voice_active)
		begin
			ph       = (c / step_len) % 32;
			exp_wave = (ph < 16) ? 4'(ph) : 4'(31 - ph);
			check_wave(exp_wave, wave_out);
			check_pitch(code, pitch_code);
			next_cycle();
			c++;
		end
		if (c < 32 * step_len)
		begin
			errors++;
			$display("note ended after %0d cycles, before one full triangle period", c);
		end
		check_wave(4'd0, wave_out); // silent after the fall
	endtask

	task automatic length_window();
		int high;
		int lo;
		int hi;
		for (int l = 0; l < 8; l++)
		begin
			write_note(NOTE_W'(40), LEN_W'(l), fx_none, '0);
			wait_active();
			high = 0;
			while (voice_active)
			begin
				next_cycle();
				high++;
			end
			lo = ((l + 1) * LEN_TICKS - 1) * FRAME_CYCLES;
			hi = (l + 1) * LEN_TICKS * FRAME_CYCLES;
			if (high < lo || high > hi)
			begin
				errors++;
				$display("length %0d: voice_active high for %0d cycles, allowed %0d to %0d",
					l, high, lo, hi);
			end
			check_wave(4'd0, wave_out);
		end
	endtask

	task automatic credit_order();
		logic [NOTE_W-1:0] codes [FIFO_DEPTH];
		write_note(NOTE_W'($urandom_range(0, 63)), 3'd7, fx_none, '0); // holds the voice
		wait_active();
		for (int i = 0; i < FIFO_DEPTH; i++)
		begin
			codes[i] = NOTE_W'(i * 16 + $urandom_range(0, 15)); // distinct per slot
			check_flag("host_ready", 1'b1, host_ready);
			write_note(codes[i], LEN_W'($urandom_range(0, 3)), fx_none, '0);
		end
		check_flag("host_ready", 1'b0, host_ready); // all credits spent
		write_note(NOTE_W'(63), 3'd0, fx_none, '0);  // dropped for lack of credit
		next_cycle();
		check_flag("host_ready", 1'b0, host_ready);
		wait_idle();
		for (int i = 0; i < FIFO_DEPTH; i++)
		begin
			wait_active();
			check_pitch(codes[i], pitch_code); // write order kept
			wait_idle();
		end
		repeat (8) next_cycle();
		check_flag("voice_active", 1'b0, voice_active); // nothing left queued
		check_flag("host_ready", 1'b1, host_ready);
	endtask

	task automatic portamento_glide();
		fx_opt_u           opt;
		logic [NOTE_W-1:0] prev;
		int                steps;
		opt = '0;
		write_note(NOTE_W'(10), 3'd0, fx_none, opt);
		wait_active();
		check_pitch(NOTE_W'(10), pitch_code);
		wait_idle();
		opt.porta.speed = 2'd1; // one code every two frame ticks
		write_note(NOTE_W'(14), 3'd7, fx_porta, opt);
		wait_active();
		prev = pitch_code;
		check_pitch(NOTE_W'(10), prev); // glide starts from the old note
		steps = 0;
		while (voice_active)
		begin
			if (pitch_code != prev)
			begin
				check_pitch(NOTE_W'(prev + 1), pitch_code);
				prev = pitch_code;
				steps++;
			end
			next_cycle();
		end
		check_pitch(NOTE_W'(14), prev);
		if (steps != 4)
		begin
			errors++;
			$display("portamento made %0d pitch steps instead of 4", steps);
		end
	endtask

	task automatic vibrato_swing(input int target, input int depth, input int speed);
		fx_opt_u           opt;
		logic [NOTE_W-1:0] prev;
		logic [NOTE_W-1:0] top;
		int                toggles;
		top             = NOTE_W'((target + depth + 1 > 63) ? 63 : target + depth + 1);
		opt.vib.depth   = 2'(depth);
		opt.vib.speed   = 2'(speed);
		write_note(NOTE_W'(target), 3'd2, fx_vibrato, opt);
		wait_active();
		prev = pitch_code;
		check_pitch(NOTE_W'(target), prev);
		toggles = 0;
		while (voice_active)
		begin
			if (pitch_code != prev)
			begin
				// must swap to the other of the two values
				check_pitch((prev == NOTE_W'(target)) ? top : NOTE_W'(target), pitch_code);
				prev = pitch_code;
				toggles++;
			end
			next_cycle();
		end
		if (toggles < 2)
		begin
			errors++;
			$display("vibrato on note %0d toggled only %0d times", target, toggles);
		end
	endtask

	task automatic reserved_effect();
		write_note(NOTE_W'(20), 3'd1, fx_reserved, 4'hc); // full depth, speed 0
		wait_active();
		while (voice_active)
		begin
			check_pitch(NOTE_W'(20), pitch_code); // unmodified
			next_cycle();
		end
	endtask

	initial
	begin
		#(WATCH_CYCLES * 20);
		$display("watchdog expired after %0d cycles, run stopped", WATCH_CYCLES);
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h62ad1fe8));
		reset       = 1'b1;
		note_valid  = 1'b0;
		note_code   = '0;
		note_length = '0;
		fx_sel      = fx_none;
		fx_opt      = '0;
		repeat (4) @(posedge clk50mhz);
		#2;
		reset = 1'b0;
		reset_values();
		plain_note();
		length_window();
		credit_order();
		portamento_glide();
		vibrato_swing(40, 2, 0);
		vibrato_swing(62, 3, 1); // top clamps at 63
		reserved_effect();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
design/synth_pkg.sv
design/note_if.sv
design/note_sequencer.sv
design/note_fifo.sv
design/fx_pitch.sv
design/tri_channel.sv
design/tri_synth_top.sv
tests/tb_tri_synth.sv

/* run_sim.sh */
#!/bin/sh
# build the triangle voice testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_tri_synth \
	-f vlog.f -o tb_tri_synth > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/tb_tri_synth > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" sim.log; then
	exit 1
fi
if ! grep -q "Verification passed" sim.log; then
	echo "simulation log holds no result"
	exit 1
fi
exit 0
